//--- verilog/flash_cfg.svh
`ifndef FLASH_CFG_SVH
`define FLASH_CFG_SVH

// width of one array word
`define NB_BIT_DATA      8

// width of an array address
`define NB_BIT_ADD_MEM   9

// highest array address for a 512 byte array
`define TOP_MEM          511

// bytes per page and the index width inside a page
`define PLENGTH          16
`define LSB_TO_CODE_PAGE 4

// bytes per sector
`define SSIZE_BYTES      64

// keeps the sector number and drops the low 6 bits
`define MASK_SECTOR      9'h1C0

`endif

//--- verilog/flash_pkg.sv
`include "flash_cfg.svh"

package flash_pkg;

   // one array word
   typedef logic [`NB_BIT_DATA-1:0] flash_byte_t;

   // one array address
   typedef logic [`NB_BIT_ADD_MEM-1:0] flash_addr_t;

   // byte position inside a page
   typedef logic [`LSB_TO_CODE_PAGE-1:0] page_index_t;

   // ------------------------------
   // core operations
   // ------------------------------
   typedef enum logic [2:0] {
      OP_PAGE_OPEN    = 3'd0,
      OP_PAGE_LOAD    = 3'd1,
      OP_PROGRAM      = 3'd2,
      OP_SECTOR_ERASE = 3'd3,
      OP_BULK_ERASE   = 3'd4,
      OP_READ_SET     = 3'd5,
      OP_READ         = 3'd6
   } flash_op_t;

endpackage

//--- verilog/flash_cmd_if.sv
`timescale 1ns/1ps

interface flash_cmd_if;
   import flash_pkg::*;

   // single cycle command strobe
   logic        cmd_valid;
   flash_op_t   cmd_op;
   // page, sector, pointer or index depending on the operation
   flash_addr_t cmd_addr;
   // byte for page loads
   flash_byte_t cmd_data;

   // page buffer needs the index and the byte
   modport buf_mp (
      input cmd_valid,
      input cmd_op,
      input cmd_addr,
      input cmd_data
   );

   // sequencer latches addresses only
   modport seq_mp (
      input cmd_valid,
      input cmd_op,
      input cmd_addr
   );

   // engine only decodes which job to start
   modport eng_mp (
      input cmd_valid,
      input cmd_op
   );

endinterface

//--- verilog/flash_addr_if.sv
`timescale 1ns/1ps

interface flash_addr_if;
   import flash_pkg::*;

   // page aligned base for program
   flash_addr_t page_base;
   // sector aligned base for sector erase
   flash_addr_t sector_base;
   // address of the next sequential read
   flash_addr_t read_ptr;
   // engine tells the sequencer a read went out
   logic        read_step;

   modport src_mp (
      output page_base,
      output sector_base,
      output read_ptr,
      input  read_step
   );

   modport dst_mp (
      input  page_base,
      input  sector_base,
      input  read_ptr,
      output read_step
   );

endinterface

//--- verilog/flash_page_buffer.sv
`timescale 1ns/1ps
`include "flash_cfg.svh"

module flash_page_buffer (
   input  logic                   se_enable,
   input  logic                   read_enable,
   flash_cmd_if.buf_mp            cmd,
   input  flash_pkg::page_index_t buf_index,
   output flash_pkg::flash_byte_t buf_byte
);
   import flash_pkg::*;

   // one register per byte of the page
   flash_byte_t page_q [0:`PLENGTH-1];
   page_index_t load_idx;
   logic        open_hit;
   logic        load_hit;

   // ------------------------------
   // command decode
   // ------------------------------
   assign open_hit = cmd.cmd_valid && (cmd.cmd_op == OP_PAGE_OPEN);
   assign load_hit = cmd.cmd_valid && (cmd.cmd_op == OP_PAGE_LOAD);

   // low address bits pick the byte inside the page
   assign load_idx = cmd.cmd_addr[`LSB_TO_CODE_PAGE-1:0];

   // ------------------------------
   // buffer storage
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         // zeros here so a page open must come first
         for (int i = 0; i < `PLENGTH; i++)
            page_q[i] <= '0;
      end
      else if (open_hit)
      begin
         // all ones leaves unloaded bytes untouched by program
         for (int i = 0; i < `PLENGTH; i++)
            page_q[i] <= '1;
      end
      else if (load_hit)
      begin
         page_q[load_idx] <= cmd.cmd_data;
      end
   end

   // engine walks the index during program
   assign buf_byte = page_q[buf_index];

   // the operation must be known whenever a strobe arrives
   a_op_known : assert property (@(posedge se_enable) disable iff (read_enable)
      cmd.cmd_valid |-> !$isunknown(cmd.cmd_op))
      else $error("page buffer saw a strobe with an unknown operation");

endmodule

//--- verilog/flash_addr_sequencer.sv
`timescale 1ns/1ps
`include "flash_cfg.svh"

module flash_addr_sequencer (
   input  logic          se_enable,
   input  logic          read_enable,
   flash_cmd_if.seq_mp   cmd,
   input  logic          busy,
   flash_addr_if.src_mp  addr
);
   import flash_pkg::*;

   logic        cmd_ok;
   logic        ptr_load;
   flash_addr_t ptr_next;

   // commands during a running job are dropped
   assign cmd_ok   = cmd.cmd_valid && !busy;
   assign ptr_load = cmd_ok && (cmd.cmd_op == OP_READ_SET);

   // next sequential address with wrap back to 0
   assign ptr_next = (addr.read_ptr == flash_addr_t'(`TOP_MEM)) ? '0 :
                     addr.read_ptr + 1'b1;

   // ------------------------------
   // base address latches
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         addr.page_base   <= '0;
         addr.sector_base <= '0;
      end
      else if (cmd_ok)
      begin
         // page base drops the index bits
         if (cmd.cmd_op == OP_PAGE_OPEN)
            addr.page_base <= {cmd.cmd_addr[`NB_BIT_ADD_MEM-1:`LSB_TO_CODE_PAGE],
                               {`LSB_TO_CODE_PAGE{1'b0}}};
         // any address inside the sector is accepted
         if (cmd.cmd_op == OP_SECTOR_ERASE)
            addr.sector_base <= cmd.cmd_addr & `MASK_SECTOR;
      end
   end

   // ------------------------------
   // read pointer
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         addr.read_ptr <= '0;
      end
      else if (ptr_load)
      begin
         // a new pointer wins over a step from an older read
         addr.read_ptr <= cmd.cmd_addr;
      end
      else if (addr.read_step)
      begin
         addr.read_ptr <= ptr_next;
      end
   end

   // a pointer step only follows a read the engine accepted
   a_step_after_read : assert property (@(posedge se_enable) disable iff (read_enable)
      addr.read_step |-> $past(cmd.cmd_valid && (cmd.cmd_op == OP_READ) && !busy))
      else $error("read pointer stepped without an accepted read");

endmodule

//--- verilog/flash_array_engine.sv
`timescale 1ns/1ps
`include "flash_cfg.svh"

module flash_array_engine (
   input  logic                   se_enable,
   input  logic                   read_enable,
   flash_cmd_if.eng_mp            cmd,
   flash_addr_if.dst_mp           addr,
   output flash_pkg::page_index_t buf_index,
   input  flash_pkg::flash_byte_t buf_byte,
   output logic                   rd_valid,
   output flash_pkg::flash_byte_t rd_data,
   output logic                   busy,
   output logic                   done
);
   import flash_pkg::*;

   // which multi-cycle job is running
   typedef enum logic [1:0] {
      MODE_IDLE,
      MODE_PROG,
      MODE_SECT,
      MODE_BULK
   } mode_t;

   // the byte array itself
   flash_byte_t mem [0:`TOP_MEM];

   mode_t       mode;
   flash_addr_t wr_cnt;
   flash_addr_t last_cnt;
   flash_addr_t wr_addr;
   flash_byte_t wr_data;
   logic        cmd_ok;
   logic        is_last;
   logic        rd_pend;

   // one byte per cycle while a job runs
   assign busy    = (mode != MODE_IDLE);
   assign cmd_ok  = cmd.cmd_valid && !busy;
   assign is_last = (wr_cnt == last_cnt);

   // page buffer is walked with the counter
   assign buf_index = wr_cnt[`LSB_TO_CODE_PAGE-1:0];

   // pending read doubles as the pointer step
   assign addr.read_step = rd_pend;

   // ------------------------------
   // write address and job length
   // ------------------------------
   always_comb
   begin
      case (mode)
         MODE_PROG:
         begin
            wr_addr  = addr.page_base + wr_cnt;
            last_cnt = flash_addr_t'(`PLENGTH - 1);
         end
         MODE_SECT:
         begin
            wr_addr  = addr.sector_base + wr_cnt;
            last_cnt = flash_addr_t'(`SSIZE_BYTES - 1);
         end
         default:
         begin
            // bulk erase sweeps from address 0
            wr_addr  = wr_cnt;
            last_cnt = flash_addr_t'(`TOP_MEM);
         end
      endcase
   end

   // program can only clear bits, erase sets them all
   assign wr_data = (mode == MODE_PROG) ? (buf_byte & mem[wr_addr]) : '1;

   // ------------------------------
   // array write port
   // ------------------------------
   always_ff @(posedge se_enable)
   begin
      if (busy)
         mem[wr_addr] <= wr_data;
   end

   // ------------------------------
   // job control
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         mode    <= MODE_IDLE;
         wr_cnt  <= '0;
         done    <= 1'b0;
         rd_pend <= 1'b0;
      end
      else
      begin
         done    <= 1'b0;
         rd_pend <= cmd_ok && (cmd.cmd_op == OP_READ);
         if (busy)
         begin
            // last byte ends the job and pulses done
            if (is_last)
            begin
               mode   <= MODE_IDLE;
               wr_cnt <= '0;
               done   <= 1'b1;
            end
            else
            begin
               wr_cnt <= wr_cnt + 1'b1;
            end
         end
         else if (cmd_ok)
         begin
            case (cmd.cmd_op)
               OP_PROGRAM:      mode <= MODE_PROG;
               OP_SECTOR_ERASE: mode <= MODE_SECT;
               OP_BULK_ERASE:   mode <= MODE_BULK;
               default:         mode <= MODE_IDLE;
            endcase
         end
      end
   end

   // ------------------------------
   // read port
   // ------------------------------
   always_ff @(posedge se_enable or posedge read_enable)
   begin
      if (read_enable)
      begin
         rd_valid <= 1'b0;
         rd_data  <= '0;
      end
      else
      begin
         rd_valid <= rd_pend;
         // pointer still holds the old value on this edge
         if (rd_pend)
            rd_data <= mem[addr.read_ptr];
      end
   end

   // a job never writes an unknown byte, as after a program over an unerased array
   a_wr_known : assert property (@(posedge se_enable) disable iff (read_enable)
      busy |-> !$isunknown(wr_data))
      else $error("job wrote an unknown byte into the array");

   // no back-pressure so a strobe during a job is lost
   a_no_cmd_busy : assert property (@(posedge se_enable) disable iff (read_enable)
      cmd.cmd_valid |-> !busy)
      else $error("command strobed while busy was dropped");

endmodule

//--- verilog/flash_core_top.sv
`timescale 1ns/1ps

module flash_core_top (
   input  logic                   se_enable,
   input  logic                   read_enable,
   input  logic                   cmd_valid,
   input  flash_pkg::flash_op_t   cmd_op,
   input  flash_pkg::flash_addr_t cmd_addr,
   input  flash_pkg::flash_byte_t cmd_data,
   output logic                   rd_valid,
   output flash_pkg::flash_byte_t rd_data,
   output logic                   busy,
   output logic                   done
);
   import flash_pkg::*;

   // buffer read path driven by the engine
   page_index_t buf_index;
   flash_byte_t buf_byte;

   flash_cmd_if  cmd_bus ();
   flash_addr_if addr_bus ();

   // ------------------------------
   // command fan-out
   // ------------------------------
   assign cmd_bus.cmd_valid = cmd_valid;
   assign cmd_bus.cmd_op    = cmd_op;
   assign cmd_bus.cmd_addr  = cmd_addr;
   assign cmd_bus.cmd_data  = cmd_data;

   // buffer and sequencer run side by side
   flash_page_buffer u_page_buffer (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .cmd         (cmd_bus),
      .buf_index   (buf_index),
      .buf_byte    (buf_byte)
   );

   flash_addr_sequencer u_addr_sequencer (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .cmd         (cmd_bus),
      .busy        (busy),
      .addr        (addr_bus)
   );

   // engine merges buffer bytes and addresses into the array
   flash_array_engine u_array_engine (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .cmd         (cmd_bus),
      .addr        (addr_bus),
      .buf_index   (buf_index),
      .buf_byte    (buf_byte),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .busy        (busy),
      .done        (done)
   );

endmodule

//--- tb/flash_core_tb.sv
`timescale 1ns/1ps
`include "flash_cfg.svh"

module flash_core_tb;
   import flash_pkg::*;

   localparam int CLK_NS     = 4;
   localparam int RST_CYCLES = 8;
   localparam int RD_LIMIT   = 4;

   logic        se_enable;
   logic        read_enable;
   logic        cmd_valid;
   flash_op_t   cmd_op;
   flash_addr_t cmd_addr;
   flash_byte_t cmd_data;
   logic        rd_valid;
   flash_byte_t rd_data;
   logic        busy;
   logic        done;

   // ------------------------------
   // stimulus table, one column per field
   // ------------------------------
   string       t_name [$];
   flash_op_t   t_op [$];
   flash_addr_t t_addr [$];
   flash_byte_t t_data [$];
   bit          t_chk [$];
   flash_byte_t t_exp [$];

   // shadow copy of array, page buffer, page base and read pointer
   flash_byte_t shadow_mem [0:`TOP_MEM];
   flash_byte_t shadow_buf [0:`PLENGTH-1];
   int          shadow_page;
   int          shadow_ptr;

   integer seed;
   int     pass_cnt;
   int     fail_cnt;
   bit     table_ready;

   flash_core_top UUT (
      .se_enable   (se_enable),
      .read_enable (read_enable),
      .cmd_valid   (cmd_valid),
      .cmd_op      (cmd_op),
      .cmd_addr    (cmd_addr),
      .cmd_data    (cmd_data),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .busy        (busy),
      .done        (done)
   );

   initial
   begin
      se_enable = 1'b0;
      forever #(CLK_NS/2) se_enable = ~se_enable;
   end

   // run length is bounded by the table size plus two full array sweeps
   initial
   begin
      int limit_ns;
      wait (table_ready);
      limit_ns = (t_name.size() + 2 * (`TOP_MEM + 1)) * CLK_NS + RST_CYCLES * CLK_NS;
      #(limit_ns);
      $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_cnt++;
      end
      else
      begin
         $display("ok  %s value %h", name, act);
         pass_cnt++;
      end
   endtask

   task automatic add_cmd(input string name, input flash_op_t op, input int a,
                          input flash_byte_t d, input bit chk);
      t_name.push_back(name);
      t_op.push_back(op);
      t_addr.push_back(flash_addr_t'(a));
      t_data.push_back(d);
      t_chk.push_back(chk);
      t_exp.push_back('0);
   endtask

   // ------------------------------
   // table contents
   // ------------------------------
   task automatic build_table();
      int scatter [3];
      int first;
      scatter = '{5, 300, 511};
      // erased array reads back all ones
      add_cmd("bulk_erase", OP_BULK_ERASE, 0, 8'h00, 1);
      foreach (scatter[k])
      begin
         add_cmd("set_scatter", OP_READ_SET, scatter[k], 8'h00, 0);
         add_cmd($sformatf("erased_rd_%0d", scatter[k]), OP_READ, 0, 8'h00, 1);
      end
      // same page programmed twice with overlapping loads
      for (int p = 0; p < 2; p++)
      begin
         first = p * 4;
         // open address sits inside the page, low bits must drop
         add_cmd("page_open", OP_PAGE_OPEN, 67, 8'h00, 0);
         for (int k = first; k < first + 8; k++)
            add_cmd("page_load", OP_PAGE_LOAD, k, flash_byte_t'($random(seed)), 0);
         add_cmd($sformatf("program_%0d", p), OP_PROGRAM, 0, 8'h00, 1);
         add_cmd("set_page", OP_READ_SET, 64, 8'h00, 0);
         for (int k = 0; k < `PLENGTH; k++)
            add_cmd($sformatf("prog%0d_rd_%0d", p, k), OP_READ, 0, 8'h00, 1);
      end
      // second sector gets data, then is erased from a mid-sector address
      add_cmd("page_open", OP_PAGE_OPEN, 8'h85, 8'h00, 0);
      for (int k = 0; k < 4; k++)
         add_cmd("page_load", OP_PAGE_LOAD, k, flash_byte_t'($random(seed)), 0);
      add_cmd("program_s2", OP_PROGRAM, 0, 8'h00, 1);
      add_cmd("sector_erase", OP_SECTOR_ERASE, 8'hB3, 8'h00, 1);
      add_cmd("set_s1", OP_READ_SET, 72, 8'h00, 0);
      for (int k = 0; k < 8; k++)
         add_cmd($sformatf("keep_rd_%0d", 72 + k), OP_READ, 0, 8'h00, 1);
      add_cmd("set_s2", OP_READ_SET, 128, 8'h00, 0);
      for (int k = 0; k < 8; k++)
         add_cmd($sformatf("erase_rd_%0d", 128 + k), OP_READ, 0, 8'h00, 1);
      // low page gets data so the wrapped reads differ from the top bytes
      add_cmd("page_open", OP_PAGE_OPEN, 0, 8'h00, 0);
      for (int k = 0; k < 2; k++)
         add_cmd("page_load", OP_PAGE_LOAD, k, flash_byte_t'($random(seed)), 0);
      add_cmd("program_low", OP_PROGRAM, 0, 8'h00, 1);
      // pointer runs off the top and wraps to 0
      add_cmd("set_wrap", OP_READ_SET, `TOP_MEM - 1, 8'h00, 0);
      for (int k = 0; k < 4; k++)
         add_cmd($sformatf("wrap_rd_%0d", k), OP_READ, 0, 8'h00, 1);
   endtask

   // reference behavior of one entry, fills the expected byte for reads
   task automatic apply_model(input int i);
      int a;
      a = int'(t_addr[i]);
      case (t_op[i])
         OP_PAGE_OPEN:
         begin
            shadow_page = a - (a % `PLENGTH);
            foreach (shadow_buf[k])
               shadow_buf[k] = 8'hFF;
         end
         OP_PAGE_LOAD:    shadow_buf[a % `PLENGTH] = t_data[i];
         OP_PROGRAM:
         begin
            for (int k = 0; k < `PLENGTH; k++)
               shadow_mem[shadow_page + k] = shadow_mem[shadow_page + k] & shadow_buf[k];
         end
         OP_SECTOR_ERASE:
         begin
            for (int k = 0; k < `SSIZE_BYTES; k++)
               shadow_mem[a - (a % `SSIZE_BYTES) + k] = 8'hFF;
         end
         OP_BULK_ERASE:
         begin
            foreach (shadow_mem[k])
               shadow_mem[k] = 8'hFF;
         end
         OP_READ_SET:     shadow_ptr = a;
         OP_READ:
         begin
            t_exp[i]   = shadow_mem[shadow_ptr];
            shadow_ptr = (shadow_ptr == `TOP_MEM) ? 0 : shadow_ptr + 1;
         end
         default:         ;
      endcase
   endtask

   function automatic int job_cycles(input flash_op_t op);
      case (op)
         OP_PROGRAM:      return `PLENGTH;
         OP_SECTOR_ERASE: return `SSIZE_BYTES;
         OP_BULK_ERASE:   return `TOP_MEM + 1;
         default:         return 0;
      endcase
   endfunction

   // one-cycle strobe, driven just after the rising edge
   task automatic send_cmd(input int i);
      @(posedge se_enable);
      #1;
      cmd_valid = 1'b1;
      cmd_op    = t_op[i];
      cmd_addr  = t_addr[i];
      cmd_data  = t_data[i];
      @(posedge se_enable);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic wait_read(input int i);
      int cycles;
      cycles = 0;
      while (!rd_valid && cycles < RD_LIMIT)
      begin
         @(posedge se_enable);
         #1;
         cycles++;
      end
      if (!rd_valid)
      begin
         $display("%s: no read data came back within %0d cycles", t_name[i], RD_LIMIT);
         fail_cnt++;
      end
      else if (cycles != 1)
      begin
         $display("%s: read data came %0d cycles after the strobe, not 1", t_name[i], cycles);
         fail_cnt++;
      end
      else
         check_value(t_name[i], t_exp[i], rd_data);
   endtask

   task automatic wait_done(input int i);
      int cycles;
      int len;
      cycles = 0;
      len    = job_cycles(t_op[i]);
      // busy is up from the sampling edge on
      check_value($sformatf("%s_busy", t_name[i]), 32'd1, busy);
      while (!done && cycles < len + 8)
      begin
         @(posedge se_enable);
         #1;
         cycles++;
      end
      if (!done)
      begin
         $display("%s: the job never signalled done within %0d cycles", t_name[i], len + 8);
         fail_cnt++;
      end
      else
      begin
         check_value(t_name[i], len, cycles);
         // busy falls on the done edge
         check_value($sformatf("%s_idle", t_name[i]), 32'd0, busy);
      end
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial
   begin
      seed        = 32'h54353d94;
      pass_cnt    = 0;
      fail_cnt    = 0;
      shadow_page = 0;
      shadow_ptr  = 0;
      read_enable = 1'b1;
      cmd_valid   = 1'b0;
      cmd_op      = OP_READ;
      cmd_addr    = '0;
      cmd_data    = '0;
      build_table();
      table_ready = 1'b1;
      repeat (RST_CYCLES) @(posedge se_enable);
      #1;
      read_enable = 1'b0;
      // outputs idle and read data cleared straight out of reset
      check_value("reset_idle", 32'd0, {busy, done, rd_valid, rd_data});
      for (int i = 0; i < t_name.size(); i++)
      begin
         apply_model(i);
         send_cmd(i);
         if (t_op[i] == OP_READ && t_chk[i])
            wait_read(i);
         else if (job_cycles(t_op[i]) != 0)
            wait_done(i);
      end
      $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- build.f
+incdir+verilog
verilog/flash_pkg.sv
verilog/flash_cmd_if.sv
verilog/flash_addr_if.sv
verilog/flash_page_buffer.sv
verilog/flash_addr_sequencer.sv
verilog/flash_array_engine.sv
verilog/flash_core_top.sv
tb/flash_core_tb.sv
